/* arcade_shell.f */
+incdir+tb
verilog/arcade_shell_pkg.sv
verilog/config_regs.sv
verilog/rom_loader.sv
verilog/control_mapper.sv
verilog/video_out.sv
verilog/sigma_delta_dac.sv
verilog/arcade_shell.sv
tb/tb_arcade_shell.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --top-module tb_arcade_shell -Mdir obj_dir -f arcade_shell.f; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_arcade_shell > "$log" 2>&1
sim_status=$?
cat "$log"

if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^All tests passed$" "$log"; then
	exit 0
fi
exit 1

/* tb/shell_model.svh */
`ifndef SHELL_MODEL_SVH
`define SHELL_MODEL_SVH

// Byte-strobed update of a 32-bit register
function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
	input logic [3:0] strb);
	logic [31:0] m;
	m = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
	return (old & ~m) | (data & m);
endfunction

// Returns {p1, p2, dsw}
// Stick bits: 0 right, 1 left, 2 down, 3 up, 4 fire_a, 5 fire_b, 6 coin, 7 start
function automatic logic [23:0] map_controls(input logic [7:0] j0, input logic [7:0] j1,
	input logic [31:0] opts);
	logic [7:0] a;
	logic [7:0] b;
	logic [3:0] da;
	logic [3:0] db;
	logic [7:0] dsw;
	a = opts[4] ? j1 : j0;
	b = opts[4] ? j0 : j1;
	// Nibble order is down, right, left, up
	da = opts[1] ? {a[1], a[2], a[3], a[0]} : {a[2], a[0], a[1], a[3]};
	db = opts[1] ? {b[1], b[2], b[3], b[0]} : {b[2], b[0], b[1], b[3]};
	dsw = {opts[11:10], opts[9:8], opts[7], opts[6], 1'b0, opts[5]};
	return {a[5], 1'b0, a[6], a[4], da, b[5], b[7], a[7], b[4], db, dsw};
endfunction

// Level 1 takes a quarter, 2 a half, 3 both
function automatic logic [5:0] scanline_dim(input logic [5:0] c, input logic [1:0] lvl);
	logic [5:0] cut;
	cut = 6'd0;
	if (lvl[0])
		cut = cut + (c >> 2);
	if (lvl[1])
		cut = cut + (c >> 1);
	return c - cut;
endfunction

// Returns {red6, green6, blue6, hsync, vsync}
function automatic logic [19:0] pixel_rule(input logic [2:0] r, input logic [2:0] g,
	input logic [1:0] b, input logic blank, input logic hs, input logic vs,
	input logic odd, input logic [1:0] lvl);
	logic [5:0] re;
	logic [5:0] ge;
	logic [5:0] be;
	logic [1:0] l;
	re = blank ? 6'd0 : {r, r};
	ge = blank ? 6'd0 : {g, g};
	be = blank ? 6'd0 : {b, b[1], b, b[1]};
	l = odd ? lvl : 2'd0;
	return {scanline_dim(re, l), scanline_dim(ge, l), scanline_dim(be, l), hs, vs};
endfunction

// Returns {carry, next accumulator}
function automatic logic [DAC_BITS:0] dac_model_step(input logic [DAC_BITS-1:0] acc,
	input logic [DAC_BITS-1:0] x);
	longint total;
	longint full;
	full = longint'(1) << DAC_BITS;
	total = longint'(acc) + longint'(x);
	if (total >= full)
		return {1'b1, total[DAC_BITS-1:0]};
	return {1'b0, total[DAC_BITS-1:0]};
endfunction

`endif

/* tb/tb_arcade_shell.sv */
`timescale 1ns/1ps

module tb_arcade_shell;
	import arcade_shell_pkg::*;

	localparam int CLK_PERIOD      = 20;
	localparam int DAC_BITS        = 16;
	localparam int REG_ITERS       = 40;
	localparam int STREAM_LEN      = 200;
	localparam int LINE_LEN        = 13;
	localparam int LOAD_EDGE       = 1 + 2;
	localparam int RESET_FALL_EDGE = LOAD_EDGE + 1;
	localparam int RUN_CYCLES      = 10 + REG_ITERS * 10 + 250 + 11 * STREAM_LEN;
	localparam int WATCHDOG_NS     = 2 * RUN_CYCLES * CLK_PERIOD;

	logic                clk_sys;
	logic                rst_n;
	axil_req_t           axi_req;
	axil_rsp_t           axi_rsp;
	rom_dl_t             rom_in;
	rom_dl_t             core_rom;
	logic                core_reset;
	joy_t                joy_0;
	joy_t                joy_1;
	core_inputs_t        core_in;
	pixel_t              pixel;
	vga_t                vga;
	logic [DAC_BITS-1:0] audio;
	logic                audio_bit;

	logic [31:0] lfsr_state;
	logic [31:0] opts_model;
	int          errors;
	int          test_errors;
	int          tests_run;
	int          failed_tests;
	int          reset_cycles;

	`include "shell_model.svh"

	arcade_shell #(.DAC_BITS(DAC_BITS)) UUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
		$display("Some tests failed");
		$finish;
	end

	always @(negedge clk_sys) begin
		if (core_reset === 1'b1)
			reset_cycles++;
	end

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = {lfsr_state[30:0],
				lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
			v = {v[62:0], lfsr_state[0]};
		end
		return v;
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		errors++;
		test_errors++;
		$display("Fail at time %0t: %s is %h, expected %h", $time, name, got, exp);
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors != 0)
			failed_tests++;
		$display("Test %0d %s: %0d errors", tests_run, name, test_errors);
		test_errors = 0;
	endtask

	task automatic next_cycle;
		@(posedge clk_sys);
		#1;
	endtask

	// --------------------
	// AXI4-Lite master
	// --------------------

	task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		axi_req.aw_valid = 1'b1;
		axi_req.aw_addr  = addr;
		axi_req.w_valid  = 1'b1;
		axi_req.w_data   = data;
		axi_req.w_strb   = strb;
		@(negedge clk_sys);
		while (!axi_rsp.aw_ready)
			@(negedge clk_sys);
		if (axi_rsp.w_ready !== 1'b1)
			report_mismatch("w_ready", 64'(axi_rsp.w_ready), 64'(1));
		next_cycle();
		axi_req.aw_valid = 1'b0;
		axi_req.w_valid  = 1'b0;
		axi_req.b_ready  = 1'b1;
		@(negedge clk_sys);
		while (!axi_rsp.b_valid)
			@(negedge clk_sys);
		if (axi_rsp.b_resp !== 2'b00)
			report_mismatch("b_resp", 64'(axi_rsp.b_resp), 64'(0));
		next_cycle();
		axi_req.b_ready = 1'b0;
	endtask

	task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
		axi_req.ar_valid = 1'b1;
		axi_req.ar_addr  = addr;
		@(negedge clk_sys);
		while (!axi_rsp.ar_ready)
			@(negedge clk_sys);
		next_cycle();
		axi_req.ar_valid = 1'b0;
		axi_req.r_ready  = 1'b1;
		@(negedge clk_sys);
		while (!axi_rsp.r_valid)
			@(negedge clk_sys);
		data = axi_rsp.r_data;
		if (axi_rsp.r_resp !== 2'b00)
			report_mismatch("r_resp", 64'(axi_rsp.r_resp), 64'(0));
		next_cycle();
		axi_req.r_ready = 1'b0;
	endtask

	task automatic set_options(input logic [31:0] word);
		axi_write(REG_STATUS, word, 4'hf);
		opts_model = word;
	endtask

	// --------------------
	// Tests
	// --------------------

	task automatic register_access;
		logic [63:0] rv;
		logic [31:0] rdata;
		if ({axi_rsp.aw_ready, axi_rsp.w_ready, axi_rsp.b_valid, axi_rsp.ar_ready,
			axi_rsp.r_valid} !== 5'b0)
			report_mismatch("axi_rsp valid and ready bits",
				64'({axi_rsp.aw_ready, axi_rsp.w_ready, axi_rsp.b_valid,
				axi_rsp.ar_ready, axi_rsp.r_valid}), 64'(0));
		if ({core_in, vga, audio_bit, core_reset} !== 46'h1)
			report_mismatch("outputs after reset", 64'({core_in, vga, audio_bit, core_reset}),
				64'(1));
		for (int i = 0; i < REG_ITERS; i++) begin
			rv = rand_bits(36);
			axi_write(REG_STATUS, rv[31:0], rv[35:32]);
			opts_model = merge_bytes(opts_model, rv[31:0], rv[35:32]);
			axi_read(REG_STATUS, rdata);
			if (rdata !== opts_model)
				report_mismatch("REG_STATUS", 64'(rdata), 64'(opts_model));
		end
		// Unmapped offset takes no write
		rv = rand_bits(32);
		axi_write(4'hc, rv[31:0], 4'hf);
		for (int a = 1; a < 16; a++) begin
			axi_read(4'(a), rdata);
			if (a != 8 && rdata !== 32'h0)
				report_mismatch("unmapped read", 64'(rdata), 64'(0));
		end
		axi_read(REG_STATUS, rdata);
		if (rdata !== opts_model)
			report_mismatch("REG_STATUS", 64'(rdata), 64'(opts_model));
		axi_read(REG_INFO, rdata);
		if (rdata !== 32'h0)
			report_mismatch("REG_INFO", 64'(rdata), 64'(0));
	endtask

	task automatic load_and_reset;
		logic [63:0] rv;
		logic [31:0] rdata;
		logic        expected;
		rom_in.download = 1'b1;
		for (int i = 0; i < 20; i++) begin
			rv = rand_bits(34);
			rom_in.wr   = rv[0];
			rom_in.addr = rv[25:1];
			rom_in.data = rv[33:26];
			next_cycle();
			if (core_reset !== 1'b1)
				report_mismatch("core_reset", 64'(core_reset), 64'(1));
		end
		axi_read(REG_INFO, rdata);
		if (rdata !== 32'h2)
			report_mismatch("REG_INFO", 64'(rdata), 64'(2));
		// Download ends and the flag is first sampled low at the next edge
		rom_in = '0;
		for (int n = 1; n <= RESET_FALL_EDGE + 2; n++) begin
			next_cycle();
			expected = (n < RESET_FALL_EDGE);
			if (core_reset !== expected)
				report_mismatch("core_reset", 64'(core_reset), 64'(expected));
		end
		axi_read(REG_INFO, rdata);
		if (rdata !== 32'h1)
			report_mismatch("REG_INFO", 64'(rdata), 64'(1));
		reset_cycles = 0;
		axi_write(REG_CONTROL, 32'h1, 4'h1);
		repeat (4) next_cycle();
		if (reset_cycles != 1)
			report_mismatch("core_reset high cycles", 64'(reset_cycles), 64'(1));
		axi_read(REG_INFO, rdata);
		if (rdata !== 32'h1)
			report_mismatch("REG_INFO", 64'(rdata), 64'(1));
	endtask

	task automatic download_forwarding;
		logic [63:0] rv;
		rom_dl_t     sent;
		for (int i = 0; i < STREAM_LEN; i++) begin
			rv = rand_bits(43);
			rom_in = rv[42:0];
			sent = rom_in;
			next_cycle();
			if (core_rom !== sent)
				report_mismatch("core_rom", 64'(core_rom), 64'(sent));
		end
		rom_in = '0;
		next_cycle();
	endtask

	task automatic control_mapping;
		logic [63:0] rv;
		logic [31:0] word;
		logic [23:0] expected;
		for (int mode = 0; mode < 4; mode++) begin
			rv = rand_bits(32);
			word = rv[31:0];
			word[1] = mode[0];
			word[4] = mode[1];
			set_options(word);
			for (int i = 0; i < STREAM_LEN; i++) begin
				rv = rand_bits(16);
				joy_0 = rv[7:0];
				joy_1 = rv[15:8];
				expected = map_controls(rv[7:0], rv[15:8], opts_model);
				next_cycle();
				if (core_in !== expected)
					report_mismatch("core_in", 64'(core_in), 64'(expected));
			end
		end
	endtask

	task automatic video_pipeline;
		logic [63:0] rv;
		logic [31:0] word;
		logic [19:0] expected;
		logic        hs_prev;
		logic        odd;
		int          line_pos;
		hs_prev = 1'b0;
		odd = 1'b0;
		line_pos = 0;
		for (int lvl = 0; lvl < 4; lvl++) begin
			word = opts_model;
			word[3:2] = lvl[1:0];
			set_options(word);
			for (int i = 0; i < STREAM_LEN; i++) begin
				rv = rand_bits(13);
				pixel.red    = rv[2:0];
				pixel.green  = rv[5:3];
				pixel.blue   = rv[7:6];
				pixel.hblank = rv[8] & rv[9];
				pixel.vblank = rv[10] & rv[11];
				pixel.vsync  = rv[12];
				pixel.hsync  = (line_pos < 2);
				line_pos = (line_pos + 1) % LINE_LEN;
				expected = pixel_rule(pixel.red, pixel.green, pixel.blue,
					pixel.hblank | pixel.vblank, pixel.hsync, pixel.vsync, odd, lvl[1:0]);
				// Parity flips on each hsync rise
				if (pixel.hsync && !hs_prev)
					odd = ~odd;
				hs_prev = pixel.hsync;
				next_cycle();
				if (vga !== expected)
					report_mismatch("vga", 64'(vga), 64'(expected));
			end
		end
	endtask

	task automatic audio_modulator;
		logic [63:0]         rv;
		logic [DAC_BITS-1:0] acc;
		logic [DAC_BITS:0]   step;
		int                  span;
		int                  done;
		acc = '0;
		done = 0;
		while (done < 2 * STREAM_LEN) begin
			rv = rand_bits(DAC_BITS + 5);
			audio = rv[DAC_BITS-1:0];
			span = 1 + int'(rv[DAC_BITS+4:DAC_BITS]);
			repeat (span) begin
				step = dac_model_step(acc, audio);
				acc = step[DAC_BITS-1:0];
				next_cycle();
				if (audio_bit !== step[DAC_BITS])
					report_mismatch("audio_bit", 64'(audio_bit), 64'(step[DAC_BITS]));
			end
			done += span;
		end
		audio = '0;
	endtask

	initial begin
		rst_n        = 1'b0;
		axi_req      = '0;
		rom_in       = '0;
		// Inputs sit at nonzero values while rst_n is low
		joy_0        = '1;
		joy_1        = '1;
		pixel        = 12'hff3;
		audio        = '1;
		lfsr_state   = 32'h14a05a3d;
		opts_model   = '0;
		errors       = 0;
		test_errors  = 0;
		tests_run    = 0;
		failed_tests = 0;
		reset_cycles = 0;
		repeat (5) @(posedge clk_sys);
		#1;
		rst_n = 1'b1;
		joy_0 = '0;
		joy_1 = '0;
		pixel = '0;
		audio = '0;
		register_access();
		finish_test("register access");
		load_and_reset();
		finish_test("load and reset");
		download_forwarding();
		finish_test("download forwarding");
		control_mapping();
		finish_test("controls");
		video_pipeline();
		finish_test("video");
		audio_modulator();
		finish_test("audio");
		$display("%0d tests run, %0d failed, %0d errors", tests_run, failed_tests, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

/* verilog/arcade_shell.sv */
`timescale 1ns/1ps

module arcade_shell #(
	parameter int DAC_BITS = 16
) (
	input  logic                           clk_sys,
	input  logic                           rst_n,
	input  arcade_shell_pkg::axil_req_t    axi_req,
	input  arcade_shell_pkg::rom_dl_t      rom_in,
	input  arcade_shell_pkg::joy_t         joy_0,
	input  arcade_shell_pkg::joy_t         joy_1,
	input  arcade_shell_pkg::pixel_t       pixel,
	input  logic [DAC_BITS-1:0]            audio,
	output arcade_shell_pkg::axil_rsp_t    axi_rsp,
	output arcade_shell_pkg::rom_dl_t      core_rom,
	output logic                           core_reset,
	output arcade_shell_pkg::core_inputs_t core_in,
	output arcade_shell_pkg::vga_t         vga,
	output logic                           audio_bit
);
	import arcade_shell_pkg::*;

	shell_status_t status;
	logic          soft_reset;
	logic          rom_loaded;

	config_regs u_config_regs (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.axi_req    (axi_req),
		.rom_loaded (rom_loaded),
		.download   (rom_in.download),
		.axi_rsp    (axi_rsp),
		.status     (status),
		.soft_reset (soft_reset)
	);

	rom_loader u_rom_loader (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.rom_in     (rom_in),
		.soft_reset (soft_reset),
		.core_rom   (core_rom),
		.rom_loaded (rom_loaded),
		.core_reset (core_reset)
	);

	control_mapper u_control_mapper (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.joy_0   (joy_0),
		.joy_1   (joy_1),
		.status  (status),
		.core_in (core_in)
	);

	video_out u_video_out (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.pixel   (pixel),
		.status  (status),
		.vga     (vga)
	);

	sigma_delta_dac #(
		.DAC_BITS (DAC_BITS)
	) u_sigma_delta_dac (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.audio     (audio),
		.audio_bit (audio_bit)
	);

endmodule

/* verilog/sigma_delta_dac.sv */
`timescale 1ns/1ps

module sigma_delta_dac #(
	parameter int DAC_BITS = 16
) (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  logic [DAC_BITS-1:0] audio,
	output logic                audio_bit
);

	logic [DAC_BITS-1:0] acc;
	logic [DAC_BITS:0]   sum;

	// Carry out of the accumulator is the output bit
	assign sum = {1'b0, acc} + {1'b0, audio};

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			acc       <= '0;
			audio_bit <= 1'b0;
		end else begin
			acc       <= sum[DAC_BITS-1:0];
			audio_bit <= sum[DAC_BITS];
		end
	end

endmodule

/* verilog/video_out.sv */
`timescale 1ns/1ps

module video_out (
	input  logic                            clk_sys,
	input  logic                            rst_n,
	input  arcade_shell_pkg::pixel_t        pixel,
	input  arcade_shell_pkg::shell_status_t status,
	output arcade_shell_pkg::vga_t          vga
);

	logic       hs_d;
	logic       odd_line;
	logic       active;
	logic [2:0] blue3;
	logic [5:0] red6;
	logic [5:0] green6;
	logic [5:0] blue6;
	logic [1:0] dim_level;

	// Scanline dimming, built from quarter and half shifts
	function automatic logic [5:0] dim(input logic [5:0] c, input logic [1:0] lvl);
		logic [5:0] r;
		case (lvl)
			2'd1:    r = c - (c >> 2);
			2'd2:    r = c - (c >> 1);
			2'd3:    r = c - (c >> 1) - (c >> 2);
			default: r = c;
		endcase
		return r;
	endfunction

	// --------------------
	// Line parity
	// --------------------

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			hs_d     <= 1'b0;
			odd_line <= 1'b0;
		end else begin
			hs_d <= pixel.hsync;
			if (pixel.hsync & ~hs_d)
				odd_line <= ~odd_line;
		end
	end

	// --------------------
	// Colour expansion
	// --------------------

	assign active = ~(pixel.hblank | pixel.vblank);

	// 2-bit blue gains its msb as a third bit
	assign blue3 = {pixel.blue, pixel.blue[1]};

	assign red6   = active ? {pixel.red, pixel.red} : 6'd0;
	assign green6 = active ? {pixel.green, pixel.green} : 6'd0;
	assign blue6  = active ? {blue3, blue3} : 6'd0;

	assign dim_level = odd_line ? status.scanlines : 2'd0;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			vga <= '0;
		end else begin
			vga.red   <= dim(red6, dim_level);
			vga.green <= dim(green6, dim_level);
			vga.blue  <= dim(blue6, dim_level);
			vga.hsync <= pixel.hsync;
			vga.vsync <= pixel.vsync;
		end
	end

endmodule

/* verilog/control_mapper.sv */
`timescale 1ns/1ps

module control_mapper (
	input  logic                            clk_sys,
	input  logic                            rst_n,
	input  arcade_shell_pkg::joy_t          joy_0,
	input  arcade_shell_pkg::joy_t          joy_1,
	input  arcade_shell_pkg::shell_status_t status,
	output arcade_shell_pkg::core_inputs_t  core_in
);
	import arcade_shell_pkg::*;

	joy_t       one;
	joy_t       two;
	logic [3:0] dirs_one;
	logic [3:0] dirs_two;
	logic [7:0] p1;
	logic [7:0] p2;
	logic [7:0] dsw;

	// Returns {down, right, left, up} as the core expects them
	function automatic logic [3:0] map_dirs(input joy_t j, input logic rot);
		logic [3:0] d;
		if (rot)
			d = {j.left, j.down, j.up, j.right};
		else
			d = {j.down, j.right, j.left, j.up};
		return d;
	endfunction

	// --------------------
	// Player selection
	// --------------------

	always_comb begin
		if (status.swap) begin
			one = joy_1;
			two = joy_0;
		end else begin
			one = joy_0;
			two = joy_1;
		end
	end

	assign dirs_one = map_dirs(one, status.rotate);
	assign dirs_two = map_dirs(two, status.rotate);

	// --------------------
	// Core bytes
	// --------------------

	assign p1 = {one.fire_b, 1'b0, one.coin, one.fire_a, dirs_one};

	// Both start buttons ride in the player two byte
	assign p2 = {two.fire_b, two.start, one.start, two.fire_a, dirs_two};

	assign dsw = {status.coins, status.lives, status.difficulty, status.bonus,
		1'b0, status.cabinet};

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			core_in <= '0;
		end else begin
			core_in.p1  <= p1;
			core_in.p2  <= p2;
			core_in.dsw <= dsw;
		end
	end

endmodule

/* verilog/rom_loader.sv */
`timescale 1ns/1ps

module rom_loader (
	input  logic                      clk_sys,
	input  logic                      rst_n,
	input  arcade_shell_pkg::rom_dl_t rom_in,
	input  logic                      soft_reset,
	output arcade_shell_pkg::rom_dl_t core_rom,
	output logic                      rom_loaded,
	output logic                      core_reset
);

	logic dl_d;
	logic dl_fall;

	// Stream toward the core, one cycle late
	always_ff @(posedge clk_sys) begin
		core_rom <= rom_in;
		if (!rst_n) begin
			core_rom.download <= 1'b0;
			core_rom.wr       <= 1'b0;
		end
	end

	// --------------------
	// Load tracking
	// --------------------

	// Fall of the retimed flag, registered before it sets rom_loaded
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			dl_d    <= 1'b0;
			dl_fall <= 1'b0;
		end else begin
			dl_d    <= core_rom.download;
			dl_fall <= dl_d & ~core_rom.download;
		end
	end

	// Stays set across soft resets
	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			rom_loaded <= 1'b0;
		else if (dl_fall)
			rom_loaded <= 1'b1;
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			core_reset <= 1'b1;
		else
			core_reset <= soft_reset | ~rom_loaded;
	end

endmodule

/* verilog/config_regs.sv */
`timescale 1ns/1ps

module config_regs (
	input  logic                            clk_sys,
	input  logic                            rst_n,
	input  arcade_shell_pkg::axil_req_t     axi_req,
	input  logic                            rom_loaded,
	input  logic                            download,
	output arcade_shell_pkg::axil_rsp_t     axi_rsp,
	output arcade_shell_pkg::shell_status_t status,
	output logic                            soft_reset
);
	import arcade_shell_pkg::*;

	logic [31:0] opt_word;
	logic [31:0] info_word;
	logic [31:0] r_data;
	logic        b_pending;
	logic        r_pending;
	logic        wr_accept;
	logic        rd_accept;

	// Each channel blocks only on its own outstanding response
	assign wr_accept = axi_req.aw_valid & axi_req.w_valid & ~b_pending;
	assign rd_accept = axi_req.ar_valid & ~r_pending;

	assign status = shell_status_t'(opt_word);

	always_comb begin
		info_word                    = '0;
		info_word[INFO_LOADED_BIT]   = rom_loaded;
		info_word[INFO_DOWNLOAD_BIT] = download;
	end

	// --------------------
	// Write channel
	// --------------------

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			opt_word   <= '0;
			soft_reset <= 1'b0;
			b_pending  <= 1'b0;
		end else begin
			soft_reset <= 1'b0;
			if (wr_accept) begin
				b_pending <= 1'b1;
				if (axi_req.aw_addr == REG_STATUS) begin
					for (int i = 0; i < 4; i++) begin
						if (axi_req.w_strb[i])
							opt_word[i*8 +: 8] <= axi_req.w_data[i*8 +: 8];
					end
				end else if (axi_req.aw_addr == REG_CONTROL) begin
					// Self-clearing, reads back as zero
					soft_reset <= axi_req.w_strb[0] & axi_req.w_data[0];
				end
			end else if (axi_req.b_ready) begin
				b_pending <= 1'b0;
			end
		end
	end

	// --------------------
	// Read channel
	// --------------------

	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			r_pending <= 1'b0;
		else if (rd_accept)
			r_pending <= 1'b1;
		else if (axi_req.r_ready)
			r_pending <= 1'b0;
	end

	always_ff @(posedge clk_sys) begin
		if (rd_accept) begin
			case (axi_req.ar_addr)
				REG_STATUS: r_data <= opt_word;
				REG_INFO:   r_data <= info_word;
				default:    r_data <= '0;
			endcase
		end
	end

	always_comb begin
		axi_rsp          = '0;
		axi_rsp.aw_ready = wr_accept;
		axi_rsp.w_ready  = wr_accept;
		axi_rsp.b_valid  = b_pending;
		axi_rsp.b_resp   = AXI_OKAY;
		axi_rsp.ar_ready = rd_accept;
		axi_rsp.r_valid  = r_pending;
		axi_rsp.r_data   = r_data;
		axi_rsp.r_resp   = AXI_OKAY;
	end

endmodule

/* verilog/arcade_shell_pkg.sv */
package arcade_shell_pkg;

	// --------------------
	// AXI4-Lite
	// --------------------

	typedef struct packed {
		logic        aw_valid;
		logic [3:0]  aw_addr;
		logic        w_valid;
		logic [31:0] w_data;
		logic [3:0]  w_strb;
		logic        b_ready;
		logic        ar_valid;
		logic [3:0]  ar_addr;
		logic        r_ready;
	} axil_req_t;

	typedef struct packed {
		logic        aw_ready;
		logic        w_ready;
		logic        b_valid;
		logic [1:0]  b_resp;
		logic        ar_ready;
		logic        r_valid;
		logic [31:0] r_data;
		logic [1:0]  r_resp;
	} axil_rsp_t;

	localparam logic [1:0] AXI_OKAY = 2'b00;

	// Register byte offsets
	localparam logic [3:0] REG_STATUS  = 4'h0;
	localparam logic [3:0] REG_CONTROL = 4'h4;
	localparam logic [3:0] REG_INFO    = 4'h8;

	// Bits of the REG_INFO readback
	localparam int INFO_LOADED_BIT   = 0;
	localparam int INFO_DOWNLOAD_BIT = 1;

	// --------------------
	// Options word
	// --------------------

	typedef struct packed {
		logic [19:0] spare_hi;
		logic [1:0]  coins;
		logic [1:0]  lives;
		logic        difficulty;
		logic        bonus;
		logic        cabinet;
		logic        swap;
		logic [1:0]  scanlines;
		logic        rotate;
		logic        spare_lo;
	} shell_status_t;

	// --------------------
	// Core side
	// --------------------

	typedef struct packed {
		logic        download;
		logic [7:0]  index;
		logic        wr;
		logic [24:0] addr;
		logic [7:0]  data;
	} rom_dl_t;

	typedef struct packed {
		logic start;
		logic coin;
		logic fire_b;
		logic fire_a;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_t;

	typedef struct packed {
		logic [7:0] p1;
		logic [7:0] p2;
		logic [7:0] dsw;
	} core_inputs_t;

	typedef struct packed {
		logic [2:0] red;
		logic [2:0] green;
		logic [1:0] blue;
		logic       hblank;
		logic       vblank;
		logic       hsync;
		logic       vsync;
	} pixel_t;

	typedef struct packed {
		logic [5:0] red;
		logic [5:0] green;
		logic [5:0] blue;
		logic       hsync;
		logic       vsync;
	} vga_t;

endpackage
